// ==== hdl/ifu_settings.svh ====
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// instruction address width in bits
`define INST_ADDR_WIDTH 32

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

// first fetch address after reset
// kept 8-byte aligned so the first packet is dual issue
`define RESET_PC 32'h0000_1000

`endif

// ==== hdl/ifu_pkg.sv ====
`default_nettype none

`include "ifu_settings.svh"

package ifu_pkg;

    // one 64-bit word from imem, as handed to predecode and the issue register
    typedef struct packed {
        logic [31:0]                 inst_hi;    // word at base + 4
        logic [31:0]                 inst_lo;    // word at base
        logic [`INST_ADDR_WIDTH-1:0] base_addr;  // always 8-byte aligned
        logic                        misaligned; // pc[2] was set, only inst_hi is live
        logic                        valid;
    } fetch_pkt_t;

    // one issue slot toward decode
    typedef struct packed {
        logic [31:0]                 inst;
        logic [`INST_ADDR_WIDTH-1:0] addr;
        logic                        pred; // static predict taken
    } slot_t;

    typedef struct packed {
        slot_t slot1; // older instruction
        slot_t slot2; // younger, NOP on single issue
        logic  valid;
    } issue_pkt_t;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;   // offset sign, set means backward
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // same word, two readings for predecode
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } inst_fmt_u;

    // fetch handshake states
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,  // req raised, waiting for ack
        FETCH_REL,  // req dropped, waiting for ack to fall
        FETCH_HOLD  // packet valid toward decode
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== hdl/pc_gen.sv ====
`default_nettype none

`include "ifu_settings.svh"

// fetch address counter
module pc_gen (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         step_i,        // packet taken by decode
    input  wire                         redirect_i,    // flush from decode
    input  wire  [`INST_ADDR_WIDTH-1:0] redirect_pc_i,
    output logic [`INST_ADDR_WIDTH-1:0] pc_o
);

    logic [`INST_ADDR_WIDTH-1:0] pc_q;
    logic [`INST_ADDR_WIDTH-1:0] pc_inc;
    logic [`INST_ADDR_WIDTH-1:0] pc_d;

    // odd word only fetched its upper half, so step 4 to get aligned again
    assign pc_inc = pc_q[2] ? `INST_ADDR_WIDTH'(4) : `INST_ADDR_WIDTH'(8);

    always_comb begin
        pc_d = pc_q;
        if (redirect_i) begin
            pc_d = redirect_pc_i; // redirect wins over step
        end else if (step_i) begin
            pc_d = pc_q + pc_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== hdl/fetch_ctrl.sv ====
`default_nettype none

`include "ifu_settings.svh"

// four-phase req/ack fetch of one 64-bit word at a time
module fetch_ctrl (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire  [`INST_ADDR_WIDTH-1:0] pc_i,
    input  wire                         flush_i,
    input  wire                         stall_i,
    input  wire                         imem_ack_i,
    input  wire  [63:0]                 imem_rdata_i,
    output logic                        imem_req_o,
    output logic [`INST_ADDR_WIDTH-1:0] imem_addr_o,
    output ifu_pkg::fetch_pkt_t         fetch_o,
    output logic                        step_o
);

    import ifu_pkg::*;

    fetch_state_e                state_q;
    fetch_state_e                state_d;
    logic                        req_q;
    logic                        discard_q;    // flush hit this handshake
    logic [`INST_ADDR_WIDTH-1:0] addr_q;
    logic                        misaligned_q;
    logic [63:0]                 word_q;
    logic                        raise_req;
    logic                        taken;

    // hold off the rising edge of req on a flush, pc is still the old one
    assign raise_req = (state_q == FETCH_REQ) && !req_q && !imem_ack_i && !flush_i;
    assign taken     = (state_q == FETCH_HOLD) && !stall_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: state_d = FETCH_REQ;
            FETCH_REQ: begin
                if (req_q && imem_ack_i) begin
                    state_d = FETCH_REL;
                end
            end
            FETCH_REL: begin
                if (!imem_ack_i) begin
                    // stale data never reaches HOLD
                    state_d = (discard_q || flush_i) ? FETCH_IDLE : FETCH_HOLD;
                end
            end
            FETCH_HOLD: begin
                if (flush_i) begin
                    state_d = FETCH_IDLE; // drop held packet
                end else if (taken) begin
                    state_d = FETCH_REQ;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= FETCH_IDLE;
            req_q     <= 1'b0;
            discard_q <= 1'b0;
            addr_q    <= '0;
        end else begin
            state_q <= state_d;
            if (raise_req) begin
                req_q  <= 1'b1;
                addr_q <= {pc_i[`INST_ADDR_WIDTH-1:3], 3'b000}; // steady until next req
            end else if (req_q && imem_ack_i) begin
                req_q <= 1'b0; // data captured below
            end
            if (state_q == FETCH_IDLE) begin
                discard_q <= 1'b0;
            end else if (flush_i && (req_q || state_q == FETCH_REL)) begin
                discard_q <= 1'b1; // let the handshake finish, then throw it away
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (raise_req) begin
            misaligned_q <= pc_i[2];
        end
        if (req_q && imem_ack_i) begin
            word_q <= imem_rdata_i;
        end
    end

    assign imem_req_o  = req_q;
    assign imem_addr_o = addr_q;
    assign step_o      = taken;

    // low word sits at the lower address
    assign fetch_o.inst_lo    = word_q[31:0];
    assign fetch_o.inst_hi    = word_q[63:32];
    assign fetch_o.base_addr  = addr_q;
    assign fetch_o.misaligned = misaligned_q;
    assign fetch_o.valid      = (state_q == FETCH_HOLD);

endmodule

`default_nettype wire

// ==== hdl/branch_predecode.sv ====
`default_nettype none

// static prediction, jal or backward conditional branch is taken
module branch_predecode (
    input  wire ifu_pkg::fetch_pkt_t fetch_i,
    output logic                     pred_lo_o,
    output logic                     pred_hi_o
);

    import ifu_pkg::*;

    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    inst_fmt_u fmt_lo;
    inst_fmt_u fmt_hi;

    // one word read as J-type and as B-type
    function automatic logic predict_taken(input inst_fmt_u f);
        logic is_jal;
        logic is_back_br;
        is_jal     = (f.j.opcode == OPC_JAL);
        is_back_br = (f.b.opcode == OPC_BRANCH) && f.b.imm12; // negative offset
        return is_jal || is_back_br;
    endfunction

    assign fmt_lo = fetch_i.inst_lo;
    assign fmt_hi = fetch_i.inst_hi;

    // flags only mean something on a live packet
    assign pred_lo_o = fetch_i.valid && predict_taken(fmt_lo);
    assign pred_hi_o = fetch_i.valid && predict_taken(fmt_hi);

endmodule

`default_nettype wire

// ==== hdl/ifu_pipe.sv ====
`default_nettype none

`include "ifu_settings.svh"

// fetch to decode register, two issue slots
module ifu_pipe (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire ifu_pkg::fetch_pkt_t fetch_i,
    input  wire                      pred_lo_i,
    input  wire                      pred_hi_i,
    input  wire                      flush_i,
    input  wire                      stall_i,
    output ifu_pkg::issue_pkt_t      issue_o
);

    import ifu_pkg::*;

    localparam slot_t NOP_SLOT = '{inst: `INST_NOP, addr: '0, pred: 1'b0};

    logic [`INST_ADDR_WIDTH-1:0] hi_addr;
    slot_t                       sel_slot1;
    slot_t                       sel_slot2;
    issue_pkt_t                  issue_d;

    assign hi_addr = fetch_i.base_addr + `INST_ADDR_WIDTH'(4);

    // slot steering by pc[2]
    always_comb begin
        if (fetch_i.misaligned) begin
            // single issue, upper half only
            sel_slot1 = '{inst: fetch_i.inst_hi, addr: hi_addr, pred: pred_hi_i};
            sel_slot2 = NOP_SLOT;
        end else begin
            sel_slot1 = '{inst: fetch_i.inst_lo, addr: fetch_i.base_addr, pred: pred_lo_i};
            sel_slot2 = '{inst: fetch_i.inst_hi, addr: hi_addr, pred: pred_hi_i};
        end
    end

    always_comb begin
        issue_d = '{slot1: sel_slot1, slot2: sel_slot2, valid: 1'b1};
        if (flush_i) begin
            issue_d = '{slot1: NOP_SLOT, slot2: NOP_SLOT, valid: 1'b0}; // addresses zeroed too
        end else if (!fetch_i.valid) begin
            // bubble, keep addresses
            issue_d.slot1.inst = `INST_NOP;
            issue_d.slot1.pred = 1'b0;
            issue_d.slot2.inst = `INST_NOP;
            issue_d.slot2.pred = 1'b0;
            issue_d.valid      = 1'b0;
        end
    end

    // flush beats stall so nothing stale survives in the register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_o <= '{slot1: NOP_SLOT, slot2: NOP_SLOT, valid: 1'b0};
        end else if (!stall_i || flush_i) begin
            issue_o <= issue_d;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ifu_top.sv ====
`default_nettype none

`include "ifu_settings.svh"

// instruction fetch front end
module ifu_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        flush_i,
    input  wire [`INST_ADDR_WIDTH-1:0] redirect_pc_i,
    input  wire                        stall_i,
    input  wire                        imem_ack_i,
    input  wire [63:0]                 imem_rdata_i,
    output wire                        imem_req_o,
    output wire [`INST_ADDR_WIDTH-1:0] imem_addr_o,
    output wire ifu_pkg::issue_pkt_t   issue_o
);

    import ifu_pkg::*;

    logic [`INST_ADDR_WIDTH-1:0] pc;
    logic                        step;
    fetch_pkt_t                  fetch_pkt;
    logic                        pred_lo;
    logic                        pred_hi;

    pc_gen pc_gen_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .step_i        (step),
        .redirect_i    (flush_i),      // every flush redirects
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .imem_ack_i   (imem_ack_i),
        .imem_rdata_i (imem_rdata_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .fetch_o      (fetch_pkt),
        .step_o       (step)
    );

    branch_predecode branch_predecode_i (
        .fetch_i   (fetch_pkt),
        .pred_lo_o (pred_lo),
        .pred_hi_o (pred_hi)
    );

    ifu_pipe ifu_pipe_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .fetch_i   (fetch_pkt),
        .pred_lo_i (pred_lo),
        .pred_hi_i (pred_hi),
        .flush_i   (flush_i),
        .stall_i   (stall_i),
        .issue_o   (issue_o)
    );

endmodule

`default_nettype wire

// ==== test/ifu_imem_model.sv ====
`default_nettype none

`include "ifu_settings.svh"

// instruction memory responder for the four-phase req/ack bus
module ifu_imem_model (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire  [1:0]                  ack_delay_i,  // cycles before ack on a new request
    input  wire                         imem_req_i,
    input  wire  [`INST_ADDR_WIDTH-1:0] imem_addr_i,
    output logic                        imem_ack_o,
    output logic [63:0]                 imem_rdata_o
);

    localparam string DATA_FILE = "test/ifu_testdata.txt";

    logic [63:0] mem [logic [`INST_ADDR_WIDTH-1:0]]; // keyed by aligned byte address

    function automatic logic [63:0] read_word(input logic [`INST_ADDR_WIDTH-1:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return {~addr, addr ^ 32'h5a5a_5a5a}; // unloaded space
    endfunction

    task automatic load_image();
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  tag;
        logic [31:0] addr;
        logic [31:0] lo;
        logic [31:0] hi;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("memory model could not open %s", DATA_FILE);
            return;
        end
        forever begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "M") begin
                code = $fscanf(fd, "%h %h %h", addr, lo, hi);
                mem[{addr[31:3], 3'b000}] = {hi, lo}; // lo word at the lower address
            end else begin
                do ch = $fgetc(fd); while (ch != 10 && ch != -1);
            end
        end
        $fclose(fd);
    endtask

    initial begin : respond
        int delay;
        int next_delay;
        bit armed;   // delay taken for this request
        imem_ack_o   = 1'b0;
        imem_rdata_o = '0;
        armed        = 1'b0;
        delay        = 0;
        next_delay   = 0;
        load_image();
        forever begin
            @(posedge clk);
            next_delay = int'(ack_delay_i); // set up in the cycle before this edge
            #10;
            if (!rst_n_i) begin
                imem_ack_o = 1'b0;
                armed      = 1'b0;
            end else if (imem_ack_o) begin
                if (!imem_req_i) imem_ack_o = 1'b0; // last phase
            end else if (imem_req_i) begin
                if (!armed) begin
                    delay = next_delay; // 0 to 3 cycles
                    armed = 1'b1;
                end
                if (delay == 0) begin
                    imem_rdata_o = read_word(imem_addr_i);
                    imem_ack_o   = 1'b1;
                    armed        = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/ifu_tb.sv ====
`default_nettype none

`include "ifu_settings.svh"

module ifu_tb;

    import ifu_pkg::*;

    localparam int    RESET_CYCLES   = 16;
    localparam int    CYCLES_PER_PKT = 40; // handshake, ack delay and stalls with margin
    localparam string DATA_FILE      = "test/ifu_testdata.txt";

    logic                        clk;
    logic                        rst_n;
    logic                        flush;
    logic [`INST_ADDR_WIDTH-1:0] redirect_pc;
    logic                        stall;
    logic [1:0]                  ack_delay;        // memory ack delay for the next request
    logic                        imem_ack;
    logic [63:0]                 imem_rdata;
    logic                        imem_req;
    logic [`INST_ADDR_WIDTH-1:0] imem_addr;
    issue_pkt_t                  issue;

    issue_pkt_t                  exp_q[$];         // expected consumed packets in order
    int                          flush_after_q[$]; // consumed count that fires a flush
    logic [`INST_ADDR_WIDTH-1:0] flush_pc_q[$];
    int                          fail_cnt = 0;     // mismatching fields
    int                          hs_err_cnt = 0;   // bus rule violations
    logic                        prev_req;
    logic                        prev_ack;
    logic [`INST_ADDR_WIDTH-1:0] prev_addr;

    ifu_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .flush_i       (flush),
        .redirect_pc_i (redirect_pc),
        .stall_i       (stall),
        .imem_ack_i    (imem_ack),
        .imem_rdata_i  (imem_rdata),
        .imem_req_o    (imem_req),
        .imem_addr_o   (imem_addr),
        .issue_o       (issue)
    );

    ifu_imem_model imem_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .ack_delay_i  (ack_delay),
        .imem_req_i   (imem_req),
        .imem_addr_i  (imem_addr),
        .imem_ack_o   (imem_ack),
        .imem_rdata_o (imem_rdata)
    );

    // reads F and E lines only
    task automatic load_testdata(output bit ok);
        int          fd;
        int          code;
        int          ch;
        bit          bad;
        logic [7:0]  tag;
        logic [31:0] v [7];
        issue_pkt_t  pkt;
        ok  = 1'b0;
        bad = 1'b0;
        fd  = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", DATA_FILE);
            return;
        end
        forever begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h",
                               v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                if (code != 7) bad = 1'b1;
                pkt.slot1 = '{inst: v[0], addr: v[1], pred: v[2][0]};
                pkt.slot2 = '{inst: v[3], addr: v[4], pred: v[5][0]};
                pkt.valid = v[6][0];
                exp_q.push_back(pkt);
            end else if (tag == "F") begin
                code = $fscanf(fd, "%d %h", v[0], v[1]);
                if (code != 2) bad = 1'b1;
                flush_after_q.push_back(int'(v[0]));
                flush_pc_q.push_back(v[1]);
            end else begin
                do ch = $fgetc(fd); while (ch != 10 && ch != -1); // rest of line
            end
        end
        $fclose(fd);
        if (bad) $display("malformed line in %s", DATA_FILE);
        ok = !bad && (exp_q.size() > 0);
    endtask

    task automatic check_slot(input string name, input slot_t got, input slot_t exp);
        if (got.inst !== exp.inst) begin
            $display("CHECK FAILED at %0t: %s inst is %h, expected %h",
                     $time, name, got.inst, exp.inst);
            fail_cnt++;
        end
        if (got.addr !== exp.addr) begin
            $display("CHECK FAILED at %0t: %s addr is %h, expected %h",
                     $time, name, got.addr, exp.addr);
            fail_cnt++;
        end
        if (got.pred !== exp.pred) begin
            $display("CHECK FAILED at %0t: %s pred is %b, expected %b",
                     $time, name, got.pred, exp.pred);
            fail_cnt++;
        end
    endtask

    task automatic check_issue(input int num, input issue_pkt_t got, input issue_pkt_t exp);
        check_slot($sformatf("packet %0d slot1", num), got.slot1, exp.slot1);
        check_slot($sformatf("packet %0d slot2", num), got.slot2, exp.slot2);
        if (got.valid !== exp.valid) begin
            $display("CHECK FAILED at %0t: packet %0d valid is %b, expected %b",
                     $time, num, got.valid, exp.valid);
            fail_cnt++;
        end
    endtask

    // bus rules sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (imem_req && !prev_req && prev_ack) begin
                $display("handshake error at %0t: imem_req_o rose while imem_ack_i was high",
                         $time);
                hs_err_cnt++;
            end
            if (imem_req && prev_req && (imem_addr !== prev_addr)) begin
                $display("handshake error at %0t: imem_addr_o changed while imem_req_o was high",
                         $time);
                hs_err_cnt++;
            end
        end
        prev_req  = imem_req;
        prev_ack  = imem_ack;
        prev_addr = imem_addr;
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : main
        bit                          data_ok;
        bit                          flush_pending;
        bit                          timed_out;
        logic [`INST_ADDR_WIDTH-1:0] pending_pc;
        int                          cycle;
        int                          limit;
        int                          consumed;
        int                          pkt_fail;
        int                          errs_before;

        void'($urandom(32'h70d8)); // one seed for stall and ack delay draws
        rst_n         = 1'b0;
        flush         = 1'b0;
        stall         = 1'b0;
        ack_delay     = '0;
        redirect_pc   = '0;
        flush_pending = 1'b0;
        pending_pc    = '0;
        timed_out     = 1'b0;
        consumed      = 0;
        pkt_fail      = 0;
        load_testdata(data_ok);
        limit = exp_q.size() * CYCLES_PER_PKT + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
        cycle = RESET_CYCLES;

        while (data_ok && consumed < exp_q.size() && !timed_out) begin
            @(posedge clk);
            #10;
            cycle++;
            flush         = flush_pending;
            redirect_pc   = pending_pc;
            flush_pending = 1'b0;
            stall         = ($urandom % 3) == 0; // about a third of the cycles
            ack_delay     = 2'($urandom % 4);    // 0 to 3 cycles
            #80; // just before the next edge
            // a flush cycle means decode drops whatever is offered
            if ((issue.valid !== 1'b0) && !stall && !flush) begin
                errs_before = fail_cnt;
                check_issue(consumed + 1, issue, exp_q[consumed]);
                consumed++;
                if (fail_cnt != errs_before) pkt_fail++;
                $display("packet %0d at %h: %s", consumed, issue.slot1.addr,
                         (fail_cnt == errs_before) ? "ok" : "mismatch");
                if (flush_after_q.size() > 0 && flush_after_q[0] == consumed) begin
                    void'(flush_after_q.pop_front());
                    pending_pc    = flush_pc_q.pop_front();
                    flush_pending = 1'b1;
                end
            end
            if (cycle >= limit && consumed < exp_q.size()) timed_out = 1'b1;
        end

        if (!data_ok) $display("test data missing or malformed, nothing was checked");
        if (timed_out) begin
            $display("timeout after %0d cycles, %0d of %0d packets consumed",
                     cycle, consumed, exp_q.size());
        end
        $display("packets %0d of %0d checked, %0d passed, %0d failed, %0d handshake errors",
                 consumed, exp_q.size(), consumed - pkt_fail, pkt_fail, hs_err_cnt);
        if (data_ok && !timed_out && fail_cnt == 0 && hs_err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ifu_testdata.txt ====
# M byte_addr inst_lo inst_hi : one 64-bit memory word, inst_lo sits at byte_addr
# F n redirect_pc : flush after the n-th consumed packet
# E s1_inst s1_addr s1_pred s2_inst s2_addr s2_pred valid : expected packet
M 00001000 00100093 00200113
M 00001008 002081b3 00209463
M 00001010 fe000ce3 0100006f
M 00001018 ffdff0ef 00000013
M 00001020 00300193 00400213
M 00002000 00500293 fe000ce3
M 00002008 00600313 0100006f
M 00002010 00209463 00700393
M 00003000 00800413 00900493
M 00003008 ffdff0ef 00209463
M 00003010 00a00513 00b00593
M 00003018 0100006f fe000ce3
M 00003020 00000013 00000013
F 4 00002004
F 7 00003000
F 9 0000300c
F 13 00001000
E 00100093 00001000 0 00200113 00001004 0 1
E 002081b3 00001008 0 00209463 0000100c 0 1
E fe000ce3 00001010 1 0100006f 00001014 1 1
E ffdff0ef 00001018 1 00000013 0000101c 0 1
E fe000ce3 00002004 1 00000013 00000000 0 1
E 00600313 00002008 0 0100006f 0000200c 1 1
E 00209463 00002010 0 00700393 00002014 0 1
E 00800413 00003000 0 00900493 00003004 0 1
E ffdff0ef 00003008 1 00209463 0000300c 0 1
E 00209463 0000300c 0 00000013 00000000 0 1
E 00a00513 00003010 0 00b00593 00003014 0 1
E 0100006f 00003018 1 fe000ce3 0000301c 1 1
E 00000013 00003020 0 00000013 00003024 0 1
E 00100093 00001000 0 00200113 00001004 0 1

// ==== build.f ====
+incdir+hdl
hdl/ifu_pkg.sv
hdl/pc_gen.sv
hdl/fetch_ctrl.sv
hdl/branch_predecode.sv
hdl/ifu_pipe.sv
hdl/ifu_top.sv
test/ifu_imem_model.sv
test/ifu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := ifu_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
